//--- src/pls_dec_pkg.sv
package pls_dec_pkg;

  // --------------------
  // Sizes
  // --------------------

  // Soft symbol width
  localparam int cDAT_W     = 4;
  // Largest positive soft value
  localparam int cDAT_MAX   = 2**(cDAT_W-1) - 1;
  // Symbols per PLS frame
  localparam int cFRAME_LEN = 64;
  localparam int cCNT_W     = $clog2(cFRAME_LEN);
  // Walsh set, one sequence per pair index
  localparam int cWALSH_N   = 32;
  localparam int cIDX_W     = $clog2(cWALSH_N);
  // 32 pair metrics of up to 14 each
  localparam int cCORR_W    = cDAT_W + 6;

  // Bit k descrambles symbol k, bit 0 first
  localparam logic [cFRAME_LEN-1:0] cSCRAMBLE_WORD = 64'h719D_83C9_5342_2DFA;

  // --------------------
  // Data types
  // --------------------

  // Positive soft value means bit 0
  typedef logic signed [cDAT_W-1:0]  dat_t;
  typedef logic signed [cDAT_W:0]    metric_t;
  typedef logic        [cIDX_W-1:0]  metric_idx_t;
  typedef logic signed [cCORR_W-1:0] corr_t;

  // Accumulator address, bank 1 holds difference metrics
  typedef struct packed {
    logic        bank;
    metric_idx_t walsh;
  } corr_addr_t;

  // Decoded 7-bit PLS code
  typedef struct packed {
    logic        pair_flip;
    metric_idx_t walsh;
    logic        invert;
  } pls_code_t;

  typedef enum logic [1:0] {IDLE, SCAN, EMIT} search_state_t;

  // Walsh chip of pair idx in sequence w, 1 means negate
  function automatic logic walsh_bit(metric_idx_t idx, metric_idx_t w);
    return ^(idx & w);
  endfunction

endpackage

//--- src/pls_dec_symb_metric.sv
`timescale 1ns/1ps

module pls_dec_symb_metric
  import pls_dec_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  //
  input  logic        isop,
  input  logic        ival,
  input  logic        ieop,
  input  dat_t        idat,
  //
  output logic        osop,
  output logic        oval,
  output logic        oeop,
  output logic        oadd_n_sub,
  output metric_idx_t oidx,
  output metric_t     odat
);

  logic              in_frame;
  logic              sym_val;
  logic [cCNT_W-1:0] sym_cnt;
  logic [cCNT_W-1:0] sym_idx;
  logic              scr_bit;
  dat_t              sat_dat;
  dat_t              dsc_dat;

  logic              dat_val;
  logic              dat_sop;
  logic              dat_eop;
  dat_t              dat;
  dat_t              dat_pre;

  logic              metric_val;
  logic              metric_sop;
  logic              metric_eop;
  metric_t           metric_add;
  metric_t           metric_sub;

  logic [1:0]        val_sr;
  logic              prev_sum;

  // --------------------
  // Descramble
  // --------------------

  // Symbols outside a frame are dropped
  assign sym_val = ival & (isop | in_frame);
  assign sym_idx = isop ? '0 : sym_cnt;
  assign scr_bit = cSCRAMBLE_WORD[sym_idx];

  // -8 folds to -7 so negation stays in range
  assign sat_dat = (idat == dat_t'(-cDAT_MAX - 1)) ? dat_t'(-cDAT_MAX) : idat;
  assign dsc_dat = scr_bit ? -sat_dat : sat_dat;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_frame <= 1'b0;
      sym_cnt  <= '0;
      dat_val  <= 1'b0;
    end else if (iclkena) begin
      if (sym_val) begin
        in_frame <= !ieop;
        sym_cnt  <= sym_idx + 1'b1;
      end
      // Pair complete on odd symbol
      dat_val <= sym_val & sym_idx[0];
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && sym_val) begin
      dat     <= dsc_dat;
      dat_pre <= dat;
      dat_sop <= (sym_idx == cCNT_W'(1));
      dat_eop <= ieop;
    end
  end

  // --------------------
  // Pair metrics
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      metric_val <= 1'b0;
    end else if (iclkena) begin
      metric_val <= dat_val;
    end
  end

  // Even plus odd, even minus odd
  always_ff @(posedge iclk) begin
    if (iclkena && dat_val) begin
      metric_sop <= dat_sop;
      metric_eop <= dat_eop;
      metric_add <= metric_t'(dat_pre) + metric_t'(dat);
      metric_sub <= metric_t'(dat_pre) - metric_t'(dat);
    end
  end

  // --------------------
  // Serializer
  // --------------------

  // Two valid cycles per pair
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr   <= '0;
      prev_sum <= 1'b0;
    end else if (iclkena) begin
      val_sr   <= metric_val ? 2'b11 : (val_sr << 1);
      prev_sum <= oval & oadd_n_sub;
    end
  end

  assign oval = val_sr[1];

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (metric_val) begin
        osop <= metric_sop;
        oeop <= metric_eop;
        // Pair index restarts with frame
        oidx <= metric_sop ? '0 : (oidx + 1'b1);
      end
      odat       <= metric_val ? metric_add : metric_sub;
      oadd_n_sub <= metric_val;
    end
  end

  // Difference never leaves without its sum just before
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && oval && !oadd_n_sub) |-> prev_sum);

endmodule

//--- src/pls_dec_walsh_corr.sv
`timescale 1ns/1ps

module pls_dec_walsh_corr
  import pls_dec_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  //
  input  logic        isop,
  input  logic        ival,
  input  logic        ieop,
  input  logic        iadd_n_sub,
  input  metric_idx_t iidx,
  input  metric_t     idat,
  //
  input  corr_addr_t  raddr,
  output corr_t       rdat,
  output logic        odone
);

  // Bank 0 sum metrics, bank 1 difference metrics
  corr_t       acc [2][cWALSH_N];

  logic        bank;
  corr_t       dat_ext;
  corr_t       dat_neg;
  corr_t       term [cWALSH_N];
  metric_idx_t last_sum_idx;

  // --------------------
  // Walsh terms
  // --------------------

  assign bank    = !iadd_n_sub;
  assign dat_ext = corr_t'(idat);
  assign dat_neg = -dat_ext;

  // Sign per sequence from pair index parity
  always_comb begin
    for (int w = 0; w < cWALSH_N; w++) begin
      term[w] = walsh_bit(iidx, metric_idx_t'(w)) ? dat_neg : dat_ext;
    end
  end

  // --------------------
  // Accumulator banks
  // --------------------

  // First metric of frame loads instead of adds
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      for (int w = 0; w < cWALSH_N; w++) begin
        acc[bank][w] <= (isop ? corr_t'(0) : acc[bank][w]) + term[w];
      end
    end
  end

  // Registered read for the peak search
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      rdat <= acc[raddr.bank][raddr.walsh];
    end
  end

  // --------------------
  // Frame done
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      odone        <= 1'b0;
      last_sum_idx <= '0;
    end else if (iclkena) begin
      // After the final difference metric
      odone <= ival & ieop & !iadd_n_sub;
      if (ival && iadd_n_sub) begin
        last_sum_idx <= iidx;
      end
    end
  end

  // Pairs arrive in order with no gaps in index
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && ival && iadd_n_sub && !isop) |->
      (iidx == metric_idx_t'(last_sum_idx + 1'b1)));

endmodule

//--- src/pls_dec_peak_search.sv
`timescale 1ns/1ps

module pls_dec_peak_search
  import pls_dec_pkg::*;
(
  input  logic          iclk,
  input  logic          ireset,
  input  logic          iclkena,
  //
  input  logic          idone,
  input  corr_t         rdat,
  output corr_addr_t    raddr,
  //
  output logic          oval,
  output pls_code_t     ocode,
  output corr_t         opeak
);

  search_state_t state;

  logic          rd_val;
  corr_addr_t    rd_addr;

  corr_t         best_mag;
  corr_addr_t    best_addr;
  logic          best_neg;

  corr_t         cur_mag;
  logic          take;
  corr_t         nxt_mag;
  corr_addr_t    nxt_addr;
  logic          nxt_neg;

  // --------------------
  // Compare
  // --------------------

  assign cur_mag = rdat[cCORR_W-1] ? -rdat : rdat;
  // Strictly greater, lowest address wins a tie
  assign take    = rd_val & (cur_mag > best_mag);

  assign nxt_mag  = take ? cur_mag : best_mag;
  assign nxt_addr = take ? rd_addr : best_addr;
  assign nxt_neg  = take ? rdat[cCORR_W-1] : best_neg;

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state  <= IDLE;
      raddr  <= '0;
      rd_val <= 1'b0;
      oval   <= 1'b0;
    end else if (iclkena) begin
      oval   <= 1'b0;
      // rdat holds a scan word one cycle later
      rd_val <= (state == SCAN);
      case (state)
        IDLE: begin
          if (idone) begin
            state <= SCAN;
            raddr <= '0;
          end
        end
        SCAN: begin
          if (raddr == '1) begin
            state <= EMIT;
          end else begin
            raddr <= corr_addr_t'(raddr + 1'b1);
          end
        end
        EMIT: begin
          state <= IDLE;
          oval  <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Best so far, cleared at scan start
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      rd_addr <= raddr;
      if (state == IDLE && idone) begin
        best_mag  <= '0;
        best_addr <= '0;
        best_neg  <= 1'b0;
      end else if (take) begin
        best_mag  <= cur_mag;
        best_addr <= rd_addr;
        best_neg  <= rdat[cCORR_W-1];
      end
      // Last word still in flight during emit
      if (state == EMIT) begin
        ocode <= '{pair_flip: nxt_addr.bank, walsh: nxt_addr.walsh, invert: nxt_neg};
        opeak <= nxt_mag;
      end
    end
  end

  // Frame gap must cover the whole scan
  assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && idone) |-> (state == IDLE));

endmodule

//--- src/pls_dec_top.sv
`timescale 1ns/1ps

module pls_dec_top
  import pls_dec_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  //
  input  logic      isop,
  input  logic      ival,
  input  logic      ieop,
  input  dat_t      idat,
  //
  output logic      oval,
  output pls_code_t ocode,
  output corr_t     opeak
);

  // Metric stream
  logic        msop;
  logic        mval;
  logic        meop;
  logic        madd_n_sub;
  metric_idx_t midx;
  metric_t     mdat;

  // Accumulator read port
  logic        done;
  corr_addr_t  raddr;
  corr_t       rdat;

  // --------------------
  // Pipeline
  // --------------------

  pls_dec_symb_metric u_symb_metric (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .isop       (isop),
    .ival       (ival),
    .ieop       (ieop),
    .idat       (idat),
    .osop       (msop),
    .oval       (mval),
    .oeop       (meop),
    .oadd_n_sub (madd_n_sub),
    .oidx       (midx),
    .odat       (mdat)
  );

  pls_dec_walsh_corr u_walsh_corr (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .isop       (msop),
    .ival       (mval),
    .ieop       (meop),
    .iadd_n_sub (madd_n_sub),
    .iidx       (midx),
    .idat       (mdat),
    .raddr      (raddr),
    .rdat       (rdat),
    .odone      (done)
  );

  pls_dec_peak_search u_peak_search (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .idone   (done),
    .rdat    (rdat),
    .raddr   (raddr),
    .oval    (oval),
    .ocode   (ocode),
    .opeak   (opeak)
  );

endmodule

//--- test/tb_pls_model.svh
`ifndef TB_PLS_MODEL_SVH
`define TB_PLS_MODEL_SVH

// Noiseless symbol amplitude
localparam int cAMP        = 5;
// 32 pairs of two symbols at full amplitude
localparam int cCLEAN_PEAK = cWALSH_N * 2 * cAMP;

// Frame under test, as sent to the DUT
dat_t      tx_frame [cFRAME_LEN];
// Expected result for tx_frame
pls_code_t model_code;
corr_t     model_peak;

// --------------------
// Encoder
// --------------------

// Codeword bit k of code c, before scrambling
function automatic logic code_bit(pls_code_t c, int k);
  logic base;
  base = (^(5'(k >> 1) & c.walsh)) ^ c.invert;
  return base ^ (k[0] & c.pair_flip);
endfunction

// Scrambled code mapped to +-cAMP plus uniform noise in +-noise
function automatic void build_frame(pls_code_t c, int noise);
  logic b;
  int   r;
  int   v;
  for (int k = 0; k < cFRAME_LEN; k++) begin
    b = code_bit(c, k) ^ cSCRAMBLE_WORD[6'(k)];
    r = $random(seed) & 32'h7fff_ffff;
    v = (b ? -cAMP : cAMP) + (r % (2 * noise + 1)) - noise;
    // Soft range of the 4-bit symbol
    if (v > cDAT_MAX) begin
      v = cDAT_MAX;
    end
    if (v < -cDAT_MAX - 1) begin
      v = -cDAT_MAX - 1;
    end
    tx_frame[6'(k)] = dat_t'(v);
  end
endfunction

// --------------------
// Decoder reference
// --------------------

// Most negative value folds in, then the scrambling bit flips the sign
function automatic int descrambled(int k);
  int v;
  v = int'(tx_frame[6'(k)]);
  if (v < -cDAT_MAX) begin
    v = -cDAT_MAX;
  end
  return cSCRAMBLE_WORD[6'(k)] ? -v : v;
endfunction

// All 64 correlations, then the first strictly largest magnitude
function automatic void model_decode();
  int acc [2 * cWALSH_N];
  int pair_sum;
  int pair_dif;
  int mag;
  int best;
  for (int a = 0; a < 2 * cWALSH_N; a++) begin
    acc[6'(a)] = 0;
  end
  for (int i = 0; i < cWALSH_N; i++) begin
    pair_sum = descrambled(2 * i) + descrambled(2 * i + 1);
    pair_dif = descrambled(2 * i) - descrambled(2 * i + 1);
    for (int w = 0; w < cWALSH_N; w++) begin
      if (^(5'(i) & 5'(w))) begin
        acc[6'(w)]            -= pair_sum;
        acc[6'(w + cWALSH_N)] -= pair_dif;
      end else begin
        acc[6'(w)]            += pair_sum;
        acc[6'(w + cWALSH_N)] += pair_dif;
      end
    end
  end
  best       = 0;
  model_code = '0;
  for (int a = 0; a < 2 * cWALSH_N; a++) begin
    mag = (acc[6'(a)] < 0) ? -acc[6'(a)] : acc[6'(a)];
    if (mag > best) begin
      best       = mag;
      model_code = '{pair_flip: 1'(a >> 5), walsh: 5'(a), invert: (acc[6'(a)] < 0)};
    end
  end
  model_peak = corr_t'(best);
endfunction

`endif

//--- test/tb_pls_dec.sv
`timescale 1ns/1ps

module tb_pls_dec
  import pls_dec_pkg::*;
();

  // Last sum taken 3 enabled cycles after ieop
  // Last difference taken one cycle later and done raised on that edge
  // oval 66 enabled cycles after done
  localparam int cEOP_TO_OVAL = 3 + 1 + 66;
  // Enabled cycles from ieop to the next isop
  localparam int cFRAME_GAP   = 70;
  localparam int cWAIT_MAX    = 200;

  logic      iclk;
  logic      ireset;
  logic      iclkena;
  logic      isop;
  logic      ival;
  logic      ieop;
  dat_t      idat;
  logic      oval;
  pls_code_t ocode;
  corr_t     opeak;

  integer    seed;
  int        gate_pct;
  int        errs;
  int        npass;
  int        nfail;
  int        ena_cnt;
  logic      last_ena;

  // Results seen at the output with the enabled cycle of arrival
  pls_code_t got_code  [$];
  corr_t     got_peak  [$];
  int        got_stamp [$];
  int        eop_stamp [$];

  `include "tb_pls_model.svh"

  pls_dec_top u_dut (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .isop    (isop),
    .ival    (ival),
    .ieop    (ieop),
    .idat    (idat),
    .oval    (oval),
    .ocode   (ocode),
    .opeak   (opeak)
  );

  always #5 iclk = ~iclk;

  // --------------------
  // Output monitor
  // --------------------

  always @(posedge iclk) begin
    last_ena = iclkena;
    if (iclkena) begin
      ena_cnt++;
    end
  end

  // oval high after an enabled edge is a fresh pulse
  always @(negedge iclk) begin
    if (oval === 1'b1 && last_ena === 1'b1) begin
      got_code.push_back(ocode);
      got_peak.push_back(opeak);
      got_stamp.push_back(ena_cnt);
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  function automatic logic draw_ena();
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return (r % 100) >= gate_pct;
  endfunction

  // Holds one input word until an enabled edge takes it
  task automatic put_symbol(input logic sop, input logic val, input logic eop, input dat_t d);
    logic taken;
    int   tries;
    taken = 1'b0;
    tries = 0;
    isop  = sop;
    ival  = val;
    ieop  = eop;
    idat  = d;
    while (!taken && tries < cWAIT_MAX) begin
      iclkena = draw_ena();
      taken   = iclkena;
      tries++;
      @(posedge iclk);
      #1;
    end
    if (!taken) begin
      $display("Clock enable stayed low for %0d cycles", cWAIT_MAX);
      errs++;
    end
  endtask

  task automatic send_frame();
    for (int k = 0; k < cFRAME_LEN; k++) begin
      put_symbol(k == 0, 1'b1, k == cFRAME_LEN - 1, tx_frame[6'(k)]);
    end
    eop_stamp.push_back(ena_cnt);
    put_symbol(1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic wait_results(input string name, input int count, output logic got);
    int n;
    n    = 0;
    isop = 1'b0;
    ival = 1'b0;
    ieop = 1'b0;
    while (got_code.size() < count && n < cWAIT_MAX) begin
      iclkena = draw_ena();
      @(posedge iclk);
      #1;
      n++;
    end
    got = (got_code.size() >= count);
    if (!got) begin
      $display("%s: no result arrived within %0d cycles", name, cWAIT_MAX);
      errs++;
    end
  endtask

  // --------------------
  // Checks
  // --------------------

  task automatic check_code(input string name, input pls_code_t exp, input pls_code_t act);
    if (act !== exp) begin
      $display("Error %s: code expected %h got %h", name, exp, act);
      errs++;
    end
  endtask

  task automatic check_peak(input string name, input corr_t exp, input corr_t act);
    if (act !== exp) begin
      $display("Error %s: peak expected %0d got %0d", name, exp, act);
      errs++;
    end
  endtask

  task automatic start_test();
    errs = 0;
    got_code.delete();
    got_peak.delete();
    got_stamp.delete();
    eop_stamp.delete();
  endtask

  task automatic end_test(input string name);
    if (errs == 0) begin
      npass++;
      $display("%s: passed", name);
    end else begin
      nfail++;
      $display("%s: failed with %0d errors", name, errs);
    end
  endtask

  // One frame and its single result
  // Clean frames are checked against the sent code
  task automatic run_frame(input string name, input int noise, input logic clean);
    pls_code_t code;
    logic      got;
    code = 7'($random(seed));
    build_frame(code, noise);
    model_decode();
    send_frame();
    wait_results(name, 1, got);
    if (got) begin
      if (clean) begin
        check_code(name, code, got_code[0]);
        check_peak(name, corr_t'(cCLEAN_PEAK), got_peak[0]);
      end else begin
        check_code(name, model_code, got_code[0]);
        check_peak(name, model_peak, got_peak[0]);
      end
      void'(got_code.pop_front());
      void'(got_peak.pop_front());
      void'(got_stamp.pop_front());
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  initial begin
    pls_code_t exp_code [$];
    corr_t     exp_peak [$];
    pls_code_t code;
    logic      got;
    iclk     = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    isop     = 1'b0;
    ival     = 1'b0;
    ieop     = 1'b0;
    idat     = '0;
    seed     = 32'h68c2_a02f;
    gate_pct = 0;
    npass    = 0;
    nfail    = 0;
    repeat (10) @(posedge iclk);
    #1;
    ireset = 1'b0;

    start_test();
    for (int n = 0; n < 20; n++) begin
      run_frame("clean_frames", 0, 1'b1);
    end
    end_test("clean_frames");

    start_test();
    for (int n = 0; n < 30; n++) begin
      run_frame("noisy_frames", 3, 1'b0);
    end
    end_test("noisy_frames");

    // Enable low about 30% of cycles with inputs held meanwhile
    start_test();
    gate_pct = 30;
    for (int n = 0; n < 10; n++) begin
      run_frame("gated_clkena", 3, 1'b0);
    end
    gate_pct = 0;
    end_test("gated_clkena");

    // Reset after 30 symbols of a frame
    start_test();
    code = 7'($random(seed));
    build_frame(code, 2);
    for (int k = 0; k < 30; k++) begin
      put_symbol(k == 0, 1'b1, 1'b0, tx_frame[6'(k)]);
    end
    ireset = 1'b1;
    ival   = 1'b0;
    isop   = 1'b0;
    repeat (3) @(posedge iclk);
    #1;
    ireset = 1'b0;
    // Rest of the broken frame must be dropped
    for (int k = 30; k < cFRAME_LEN; k++) begin
      put_symbol(1'b0, 1'b1, k == cFRAME_LEN - 1, tx_frame[6'(k)]);
    end
    for (int n = 0; n < 100; n++) begin
      put_symbol(1'b0, 1'b0, 1'b0, '0);
    end
    if (got_code.size() != 0) begin
      $display("reset_mid_frame: a result came out after reset with no complete frame");
      errs++;
    end
    run_frame("reset_mid_frame", 2, 1'b0);
    end_test("reset_mid_frame");

    // Minimum gap so results overlap the next frame
    start_test();
    for (int f = 0; f < 10; f++) begin
      code = 7'($random(seed));
      build_frame(code, 3);
      model_decode();
      exp_code.push_back(model_code);
      exp_peak.push_back(model_peak);
      for (int k = 0; k < cFRAME_LEN; k++) begin
        put_symbol(k == 0, 1'b1, k == cFRAME_LEN - 1, tx_frame[6'(k)]);
      end
      eop_stamp.push_back(ena_cnt);
      if (f < 9) begin
        for (int n = 0; n < cFRAME_GAP - 1; n++) begin
          put_symbol(1'b0, 1'b0, 1'b0, '0);
        end
      end
    end
    wait_results("back_to_back", 10, got);
    if (got_code.size() != 10) begin
      $display("back_to_back: expected 10 results but %0d arrived", got_code.size());
      errs++;
    end else begin
      for (int f = 0; f < 10; f++) begin
        check_code("back_to_back", exp_code[f], got_code[f]);
        check_peak("back_to_back", exp_peak[f], got_peak[f]);
        if (got_stamp[f] - eop_stamp[f] != cEOP_TO_OVAL) begin
          $display("Error back_to_back: latency expected %0d got %0d",
                   cEOP_TO_OVAL, got_stamp[f] - eop_stamp[f]);
          errs++;
        end
      end
    end
    end_test("back_to_back");

    $display("tests passed %0d, failed %0d", npass, nfail);
    if (nfail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+test
src/pls_dec_pkg.sv
src/pls_dec_symb_metric.sv
src/pls_dec_walsh_corr.sv
src/pls_dec_peak_search.sv
src/pls_dec_top.sv
test/tb_pls_dec.sv

//--- run.sh
#!/bin/sh
# Build and run the PLS header decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pls_dec -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_pls_dec)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
